// File: mipsPkg.sv
/*
 * MIPS subset definitions
 * word and register-index types, the instruction word union,
 * opcode / funct encodings and the internal ALU and write-back selects
 */
`default_nettype none

package mipsPkg;

  // ====================================================================
  // basic types
  // ====================================================================
  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  // fixed register indices
  localparam regIdxT regZero = 5'd0;
  // jal return address
  localparam regIdxT regLink = 5'd31;

  // ====================================================================
  // encodings
  // ====================================================================
  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // internal ALU operation
  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluSlt  = 3'd4,
    aluNone = 3'd7
  } aluOpT;

  // register write-back source
  typedef enum logic [1:0] {
    wbAlu  = 2'd0,
    wbMem  = 2'd1,
    wbLink = 2'd2
  } wbSelT;

  // ====================================================================
  // instruction word, three views of the same 32 bits
  // ====================================================================
  typedef struct packed {
    opcodeT      op;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [4:0]  shamt;
    functT       funct;
  } rFormatT;

  typedef struct packed {
    opcodeT      op;
    regIdxT      rs;
    regIdxT      rt;
    logic [15:0] imm;
  } iFormatT;

  typedef struct packed {
    opcodeT      op;
    logic [25:0] target;
  } jFormatT;

  typedef union packed {
    rFormatT r;
    iFormatT i;
    jFormatT j;
  } instrT;

endpackage

`default_nettype wire

// File: ctrlIf.sv
/*
 * decoded control bundle
 * carries control fields and instruction operands from decode
 * to execute, result and the register write path
 */
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import mipsPkg::*; ();

  // control fields
  aluOpT       aluOp;
  logic        aluSrcImm;
  logic        memRead;
  logic        memWrite;
  logic        regWrite;
  wbSelT       wbSel;
  regIdxT      destReg;
  logic        isBranch;
  logic        isJump;
  logic        isJr;
  // operand fields from the instruction word
  wordT        immExt;
  logic [25:0] jumpTarget;

  // producer side
  modport decode (
    output aluOp, aluSrcImm, memRead, memWrite, regWrite, wbSel,
           destReg, isBranch, isJump, isJr, immExt, jumpTarget
  );

  // ALU and compare
  modport execute (input aluOp, aluSrcImm, isBranch, immExt);

  // write-back, memory strobes, next pc
  modport result (
    input memRead, memWrite, regWrite, wbSel, destReg,
          isJump, isJr, immExt, jumpTarget
  );

  // register write port view
  modport wrPath (input regWrite, destReg, wbSel);

endinterface

`default_nettype wire

// File: mipsDecode.sv
/*
 * main control and ALU control
 * opcode read through the I view, funct through the R view;
 * produces all control fields of the single-cycle datapath
 */
`timescale 1ns/1ps
`default_nettype none

module mipsDecode import mipsPkg::*; (
  input  instrT     instr,
  ctrlIf.decode     ctrl
);

  // R-type funct is a legal ALU op
  logic rAluOk;

  // ====================================================================
  // operand fields
  // ====================================================================
  // sign-extended 16-bit offset for lw / sw / beq
  assign ctrl.immExt     = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign ctrl.jumpTarget = instr.j.target;

  // ====================================================================
  // ALU control
  // ====================================================================
  always_comb begin
    rAluOk     = 1'b0;
    ctrl.aluOp = aluNone;
    case (instr.i.op)
      opRtype: begin
        rAluOk = 1'b1;
        case (instr.r.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          // jr and unknown funct, no ALU result
          default: rAluOk = 1'b0;
        endcase
      end
      // address calc
      opLw, opSw: ctrl.aluOp = aluAdd;
      // compare by subtraction
      opBeq:      ctrl.aluOp = aluSub;
      default:    ctrl.aluOp = aluNone;
    endcase
  end

  // ====================================================================
  // main control
  // ====================================================================
  always_comb begin
    // defaults: nothing written, sequential pc
    ctrl.aluSrcImm = 1'b0;
    ctrl.memRead   = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.wbSel     = wbAlu;
    ctrl.destReg   = regZero;
    ctrl.isBranch  = 1'b0;
    ctrl.isJump    = 1'b0;
    ctrl.isJr      = 1'b0;
    case (instr.i.op)
      opRtype: begin
        ctrl.destReg  = instr.r.rd;
        ctrl.regWrite = rAluOk;
        ctrl.isJr     = (instr.r.funct == fnJr);
      end
      opLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.wbSel     = wbMem;
        // load target is rt
        ctrl.destReg   = instr.i.rt;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      opBeq: ctrl.isBranch = 1'b1;
      opJ:   ctrl.isJump   = 1'b1;
      opJal: begin
        ctrl.isJump   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = wbLink;
        ctrl.destReg  = regLink;
      end
      // unknown opcode falls through as a no-op
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: mipsRegFile.sv
/*
 * general purpose register file
 * 32 x 32 bits, two combinational read ports, one write port;
 * register 0 reads as zero and ignores writes
 */
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile import mipsPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regIdxT rsIdx,
  input  regIdxT rtIdx,
  input  logic   writeEn,
  input  regIdxT writeIdx,
  input  wordT   writeData,
  output wordT   rsData,
  output wordT   rtData
);

  wordT regs [32];

  // write at rising edge, whole array cleared on reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (writeEn && (writeIdx != regZero)) begin
      regs[writeIdx] <= writeData;
    end
  end

  // read ports
  // r0 forced to zero on read as well
  assign rsData = (rsIdx == regZero) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == regZero) ? '0 : regs[rtIdx];

endmodule

`default_nettype wire

// File: mipsExecute.sv
/*
 * execute stage
 * second operand select, integer ALU and beq equality compare
 */
`timescale 1ns/1ps
`default_nettype none

module mipsExecute import mipsPkg::*; (
  ctrlIf.execute ctrl,
  input  wordT   rsData,
  input  wordT   rtData,
  output wordT   aluResult,
  output logic   branchTaken
);

  wordT opB;
  wordT diff;
  logic lessThan;

  // ====================================================================
  // operand select
  // ====================================================================
  // immediate for lw / sw, register otherwise
  assign opB = ctrl.aluSrcImm ? ctrl.immExt : rtData;

  // shared subtractor, feeds sub and the branch compare
  assign diff     = rsData - opB;
  // signed compare for slt
  assign lessThan = $signed(rsData) < $signed(opB);

  // ====================================================================
  // ALU
  // ====================================================================
  always_comb begin
    case (ctrl.aluOp)
      aluAdd:  aluResult = rsData + opB;
      aluSub:  aluResult = diff;
      aluAnd:  aluResult = rsData & opB;
      aluOr:   aluResult = rsData | opB;
      aluSlt:  aluResult = {31'd0, lessThan};
      default: aluResult = '0;
    endcase
  end

  // beq taken when rs - rt is zero
  assign branchTaken = ctrl.isBranch && (diff == '0);

endmodule

`default_nettype wire

// File: mipsResult.sv
/*
 * result stage
 * write-back select, data memory address and active-low strobes,
 * next-pc selection and the program counter register
 */
`timescale 1ns/1ps
`default_nettype none

module mipsResult import mipsPkg::*; #(
  parameter int   DataAddrWidth = 7,
  parameter wordT ResetPc       = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  ctrlIf.result                    ctrl,
  input  wordT                     aluResult,
  input  wordT                     rsData,
  input  wordT                     rtData,
  input  logic                     branchTaken,
  input  wordT                     memReadData,
  output wordT                     pc,
  output logic [DataAddrWidth-1:0] memAddr,
  output wordT                     memWriteData,
  output logic                     memCen,
  output logic                     memWen,
  output logic                     rfWriteEn,
  output regIdxT                   rfWriteAddr,
  output wordT                     rfWriteData
);

  wordT pcPlus4;
  wordT pcPlus8;
  wordT jumpPc;
  wordT branchPc;
  wordT nextPc;

  // ====================================================================
  // write-back
  // ====================================================================
  assign pcPlus4 = pc + 32'd4;
  // link value for jal is pc + 8
  assign pcPlus8 = pc + 32'd8;

  always_comb begin
    case (ctrl.wbSel)
      wbMem:   rfWriteData = memReadData;
      wbLink:  rfWriteData = pcPlus8;
      default: rfWriteData = aluResult;
    endcase
  end

  assign rfWriteAddr = ctrl.destReg;
  // no commit while reset is held
  assign rfWriteEn   = rst && ctrl.regWrite;

  // ====================================================================
  // data memory port
  // ====================================================================
  // word address, byte offset bits dropped
  assign memAddr      = aluResult[DataAddrWidth+1:2];
  assign memWriteData = rtData;
  // active low, both held high in reset
  assign memCen = !(rst && (ctrl.memRead || ctrl.memWrite));
  assign memWen = !(rst && ctrl.memWrite);

  // ====================================================================
  // next pc
  // ====================================================================
  // region bits from pc + 4, word target below
  assign jumpPc   = {pcPlus4[31:28], ctrl.jumpTarget, 2'b00};
  assign branchPc = pcPlus4 + {ctrl.immExt[29:0], 2'b00};

  // priority j/jal, beq, jr, sequential
  always_comb begin
    if (ctrl.isJump) begin
      nextPc = jumpPc;
    end else if (branchTaken) begin
      nextPc = branchPc;
    end else if (ctrl.isJr) begin
      nextPc = rsData;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= ResetPc;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

// File: mipsCore.sv
/*
 * single-cycle MIPS core, top level
 * connects decode, register file, execute and result;
 * plain instruction, data memory and register-write observation ports
 */
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; #(
  parameter int   DataAddrWidth = 7,
  parameter wordT ResetPc       = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  // instruction side
  output wordT                     instrAddr,
  input  wordT                     instr,
  // data memory side, SRAM style
  output logic [DataAddrWidth-1:0] memAddr,
  output wordT                     memWriteData,
  output logic                     memCen,
  output logic                     memWen,
  input  wordT                     memReadData,
  // register write port, for observation
  output logic                     rfWriteEn,
  output regIdxT                   rfWriteAddr,
  output wordT                     rfWriteData
);

  instrT instrView;
  wordT  rsData;
  wordT  rtData;
  wordT  aluResult;
  logic  branchTaken;
  wordT  pc;

  ctrlIf ctrlBus ();

  // field view of the fetched word
  assign instrView = instr;
  assign instrAddr = pc;

  // ====================================================================
  // blocks
  // ====================================================================
  mipsDecode uDecode (
    .instr (instrView),
    .ctrl  (ctrlBus)
  );

  // write port fed back from result
  mipsRegFile uRegFile (
    .clk       (clk),
    .rst       (rst),
    .rsIdx     (instrView.r.rs),
    .rtIdx     (instrView.r.rt),
    .writeEn   (rfWriteEn),
    .writeIdx  (rfWriteAddr),
    .writeData (rfWriteData),
    .rsData    (rsData),
    .rtData    (rtData)
  );

  mipsExecute uExecute (
    .ctrl        (ctrlBus),
    .rsData      (rsData),
    .rtData      (rtData),
    .aluResult   (aluResult),
    .branchTaken (branchTaken)
  );

  mipsResult #(
    .DataAddrWidth (DataAddrWidth),
    .ResetPc       (ResetPc)
  ) uResult (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrlBus),
    .aluResult    (aluResult),
    .rsData       (rsData),
    .rtData       (rtData),
    .branchTaken  (branchTaken),
    .memReadData  (memReadData),
    .pc           (pc),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memCen       (memCen),
    .memWen       (memWen),
    .rfWriteEn    (rfWriteEn),
    .rfWriteAddr  (rfWriteAddr),
    .rfWriteData  (rfWriteData)
  );

endmodule

`default_nettype wire

// File: tbIsaModel.svh
/*
 * ISA reference model for the MIPS subset testbench
 * single-instruction step with expected port values,
 * xorshift generator and the random program builder
 */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// ======================================================================
// encodings, from the MIPS reference tables
// ======================================================================
localparam logic [5:0] codeRtype = 6'h00;
localparam logic [5:0] codeJ     = 6'h02;
localparam logic [5:0] codeJal   = 6'h03;
localparam logic [5:0] codeBeq   = 6'h04;
localparam logic [5:0] codeLw    = 6'h23;
localparam logic [5:0] codeSw    = 6'h2b;
localparam logic [5:0] fnCodeJr  = 6'h08;
localparam logic [5:0] fnCodeAdd = 6'h20;
localparam logic [5:0] fnCodeSub = 6'h22;
localparam logic [5:0] fnCodeAnd = 6'h24;
localparam logic [5:0] fnCodeOr  = 6'h25;
localparam logic [5:0] fnCodeSlt = 6'h2a;

logic [31:0] rngState;
// architectural state
logic [31:0] modelPc;
logic [31:0] modelRegs [32];
logic [31:0] modelMem [128];
// expected ports of the last stepped instruction
logic                     expWe;
logic [4:0]               expWa;
logic [31:0]              expWd;
logic                     expCen;
logic                     expWen;
logic [DataAddrWidth-1:0] expMa;
logic [31:0]              expMd;

function automatic logic [31:0] nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  return rngState;
endfunction

// every address bit mixes into the word
function automatic logic [31:0] memFill(input int addr);
  return (32'(addr) * 32'h9e3779b9) ^ {16'(addr), 16'hc3a5};
endfunction

function automatic void resetModel();
  modelPc = ResetPc;
  for (int k = 0; k < 32; k++) begin
    modelRegs[k] = 32'h0;
  end
  for (int k = 0; k < 128; k++) begin
    modelMem[k] = memFill(k);
  end
endfunction

// ======================================================================
// one instruction
// ======================================================================
function automatic void stepModel(input logic [31:0] w);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] pc4;
  logic [31:0] addr;
  logic [31:0] npc;
  a      = modelRegs[w[25:21]];
  b      = modelRegs[w[20:16]];
  imm    = {{16{w[15]}}, w[15:0]};
  pc4    = modelPc + 32'd4;
  addr   = a + imm;
  npc    = pc4;
  expWe  = 1'b0;
  expWa  = 5'd0;
  expWd  = 32'd0;
  expCen = 1'b1;
  expWen = 1'b1;
  // word address, byte bits dropped
  expMa  = addr[DataAddrWidth+1:2];
  expMd  = b;
  case (w[31:26])
    codeRtype: begin
      expWe = 1'b1;
      expWa = w[15:11];
      case (w[5:0])
        fnCodeAdd: expWd = a + b;
        fnCodeSub: expWd = a - b;
        fnCodeAnd: expWd = a & b;
        fnCodeOr:  expWd = a | b;
        fnCodeSlt: expWd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        fnCodeJr: begin
          expWe = 1'b0;
          npc   = a;
        end
        default: expWe = 1'b0;
      endcase
    end
    codeLw: begin
      expWe  = 1'b1;
      expWa  = w[20:16];
      expWd  = modelMem[expMa];
      expCen = 1'b0;
    end
    codeSw: begin
      expCen = 1'b0;
      expWen = 1'b0;
      modelMem[expMa] = b;
    end
    codeBeq: npc = (a == b) ? pc4 + (imm << 2) : pc4;
    codeJ:   npc = {pc4[31:28], w[25:0], 2'b00};
    codeJal: begin
      npc   = {pc4[31:28], w[25:0], 2'b00};
      expWe = 1'b1;
      expWa = 5'd31;
      // link skips the slot after jal
      expWd = modelPc + 32'd8;
    end
    default: ;
  endcase
  // r0 stays zero
  if (expWe && expWa != 5'd0) begin
    modelRegs[expWa] = expWd;
  end
  modelPc = npc;
endfunction

// ======================================================================
// program generation
// ======================================================================
function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] fn);
  return {codeRtype, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] tgt);
  return {op, tgt};
endfunction

// model-only dry run
// branches and jumps go forward, so an endless loop closes through a jr;
// the last jr seen when the budget runs out is inside that loop
function automatic int findLoopingJr();
  logic [31:0] w;
  int lastJr;
  lastJr = -1;
  resetModel();
  for (int s = 0; s < StepBudget; s++) begin
    if (modelPc == HaltPc) begin
      return -1;
    end
    w = instrMem[modelPc[8:2]];
    if (w[31:26] == codeRtype && w[5:0] == fnCodeJr) begin
      lastJr = int'(modelPc[8:2]);
    end
    stepModel(w);
  end
  return lastJr;
endfunction

function automatic void buildProgram();
  logic [31:0] r;
  logic [31:0] f;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [15:0] offs;
  int          span;
  int          loopJr;
  logic        sawJal;
  sawJal = 1'b0;
  for (int k = 0; k < 128; k++) begin
    instrMem[k] = 32'h0;
  end
  for (int i = 0; i < ProgLen; i++) begin
    r    = nextRand();
    f    = nextRand();
    rs   = {2'b00, f[2:0]};
    rt   = {2'b00, f[6:4]};
    rd   = {2'b00, f[9:7]};
    // words 0..119, the top 8 words take the register dump
    offs = 16'((int'(f[31:16]) % 120) * 4);
    // forward targets land at most on the dump sequence
    span = ProgLen - i;
    case (int'(r % 32'd12))
      0, 11: instrMem[i] = encodeR(rs, rt, rd, fnCodeAdd);
      1:     instrMem[i] = encodeR(rs, rt, rd, fnCodeSub);
      2:     instrMem[i] = encodeR(rs, rt, rd, fnCodeAnd);
      3:     instrMem[i] = encodeR(rs, rt, rd, fnCodeOr);
      4:     instrMem[i] = encodeR(rs, rt, rd, fnCodeSlt);
      5:     instrMem[i] = encodeI(codeLw, 5'd0, rt, offs);
      6:     instrMem[i] = encodeI(codeSw, 5'd0, rt, offs);
      // same register half the time, so some branches are taken
      7:     instrMem[i] = encodeI(codeBeq, rs, f[3] ? rs : rt, 16'(int'(f[25:10]) % span));
      8:     instrMem[i] = encodeJ(codeJ, 26'(i + 1 + int'(f[25:10]) % span));
      9: begin
        instrMem[i] = encodeJ(codeJal, 26'(i + 1 + int'(f[25:10]) % span));
        sawJal      = 1'b1;
      end
      default: begin
        // jr only once r31 has a link value
        if (sawJal) begin
          instrMem[i] = encodeR(5'd31, 5'd0, 5'd0, fnCodeJr);
        end else begin
          instrMem[i] = encodeR(rs, rt, rd, fnCodeOr);
        end
      end
    endcase
  end
  // dump r0..r7 to words 120..127, then spin
  for (int k = 0; k < 8; k++) begin
    instrMem[ProgLen + k] = encodeI(codeSw, 5'd0, 5'(k), 16'((120 + k) * 4));
  end
  instrMem[HaltIdx] = encodeJ(codeJ, 26'(HaltIdx));
  // looping jr turned into add r0
  for (int t = 0; t < ProgLen; t++) begin
    loopJr = findLoopingJr();
    if (loopJr >= 0) begin
      instrMem[loopJr] = encodeR(5'd0, 5'd0, 5'd0, fnCodeAdd);
    end
  end
endfunction

`endif

// File: tbMips.sv
/*
 * testbench for the single-cycle MIPS core
 * random program from a fixed seed, combinational instruction and
 * data memories, per-cycle compare against the ISA model
 */
`timescale 1ns/1ps
`default_nettype none

module tbMips;

  localparam int          DataAddrWidth = 7;
  // instruction memory indexing assumes a zero reset address
  localparam logic [31:0] ResetPc       = 32'h0;
  localparam int          ProgLen       = 64;
  // 8 dump stores follow the random part
  localparam int          HaltIdx       = ProgLen + 8;
  localparam logic [31:0] HaltPc        = ResetPc + 32'(HaltIdx * 4);
  localparam int          StepBudget    = 2000;
  localparam int          RunTimeout    = 4000;
  localparam logic [31:0] Seed          = 32'd70423;

  logic                     clk;
  logic                     rst;
  logic [31:0]              instrAddr;
  logic [31:0]              instr;
  logic [DataAddrWidth-1:0] memAddr;
  logic [31:0]              memWriteData;
  logic                     memCen;
  logic                     memWen;
  logic [31:0]              memReadData;
  logic                     rfWriteEn;
  logic [4:0]               rfWriteAddr;
  logic [31:0]              rfWriteData;

  logic [31:0] instrMem [128];
  logic [31:0] dataMem [128];
  // word fetched while reset is held
  logic [31:0] resetWord;
  int          errorCount;
  int          checkCount;
  int          cycles;
  logic        done;

  `include "tbIsaModel.svh"

  mipsCore #(
    .DataAddrWidth (DataAddrWidth),
    .ResetPc       (ResetPc)
  ) dut (
    .clk          (clk),
    .rst          (rst),
    .instrAddr    (instrAddr),
    .instr        (instr),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memCen       (memCen),
    .memWen       (memWen),
    .memReadData  (memReadData),
    .rfWriteEn    (rfWriteEn),
    .rfWriteAddr  (rfWriteAddr),
    .rfWriteData  (rfWriteData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // memories
  // ====================================================================
  // reads answer in the same cycle
  assign instr       = !rst ? resetWord : instrMem[instrAddr[8:2]];
  assign memReadData = dataMem[memAddr];

  // fill while in reset, write on both strobes low
  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < 128; k++) begin
        dataMem[k] <= memFill(k);
      end
    end else if (!memCen && !memWen) begin
      dataMem[memAddr] <= memWriteData;
    end
  end

  // ====================================================================
  // checking
  // ====================================================================
  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] want);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // model step, then every port the model defines
  task automatic compareStep(input logic [31:0] w);
    string where;
    where = $sformatf("pc %h instr %h:", modelPc, w);
    stepModel(w);
    checkValue({where, " rfWriteEn"}, 32'(rfWriteEn), 32'(expWe));
    if (expWe) begin
      checkValue({where, " rfWriteAddr"}, 32'(rfWriteAddr), 32'(expWa));
      checkValue({where, " rfWriteData"}, rfWriteData, expWd);
    end
    checkValue({where, " memCen"}, 32'(memCen), 32'(expCen));
    checkValue({where, " memWen"}, 32'(memWen), 32'(expWen));
    if (!expCen) begin
      checkValue({where, " memAddr"}, 32'(memAddr), 32'(expMa));
    end
    if (!expWen) begin
      checkValue({where, " memWriteData"}, memWriteData, expMd);
    end
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    rst        = 1'b1;
    resetWord  = 32'h0;
    rngState   = Seed;
    errorCount = 0;
    checkCount = 0;
    cycles     = 0;
    done       = 1'b0;
    buildProgram();
    resetModel();
    @(posedge clk);
    rst <= 1'b0;
    // ten reset cycles, pc parked and strobes idle
    // a store and a load in turn, neither may commit
    for (int c = 0; c < 10; c++) begin
      resetWord <= (c % 2 == 0) ? encodeI(codeSw, 5'd0, 5'd1, 16'd0)
                                : encodeI(codeLw, 5'd0, 5'd1, 16'd0);
      @(negedge clk);
      checkValue("reset instrAddr", instrAddr, ResetPc);
      checkValue("reset memCen", 32'(memCen), 32'd1);
      checkValue("reset memWen", 32'(memWen), 32'd1);
      checkValue("reset rfWriteEn", 32'(rfWriteEn), 32'd0);
      @(posedge clk);
    end
    rst <= 1'b1;
    // mid-cycle sampling, one instruction per cycle
    while (!done && cycles < RunTimeout) begin
      @(negedge clk);
      cycles++;
      checkValue("instrAddr", instrAddr, modelPc);
      if (modelPc == HaltPc) begin
        done = 1'b1;
      end else begin
        compareStep(instrMem[modelPc[8:2]]);
      end
    end
    if (!done) begin
      errorCount++;
      $display("Timeout: PC never reached the halt loop within %0d cycles", cycles);
    end
    // whole data memory, including the register dump
    for (int k = 0; k < 128; k++) begin
      checkValue($sformatf("dataMem[%0d]", k), dataMem[k], modelMem[k]);
    end
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mipsPkg.sv
ctrlIf.sv
mipsDecode.sv
mipsRegFile.sv
mipsExecute.sv
mipsResult.sv
mipsCore.sv
tbMips.sv

// File: run.sh
#!/bin/sh
# build the MIPS core testbench with Verilator, run it, scan the log
verilator --binary --timing --timescale 1ns/1ps --top-module tbMips -f vlog.f -o simMips \
  && ./obj_dir/simMips > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1 || exit 0
